// File: logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 64;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [2:0]        size_t;  // log2 of byte count

    typedef enum logic [1:0] {
        wr_idle    = 2'b00,
        wr_aw_wait = 2'b01,
        wr_w_wait  = 2'b11,
        wr_b_done  = 2'b10
    } wr_state_e;

    typedef enum logic [1:0] {
        rd_idle    = 2'b00,
        rd_ar_wait = 2'b01,
        rd_r_wait  = 2'b11,
        rd_done    = 2'b10
    } rd_state_e;

endpackage

`default_nettype wire

// File: logic/req_format.sv
`timescale 1ns/100ps
`default_nettype none

module req_format #(
    parameter int NUM_PORTS = 2
) (
    input  mem_pkg::addr_t [NUM_PORTS-1:0] addr_i,
    input  mem_pkg::data_t [NUM_PORTS-1:0] wdata_i,
    input  mem_pkg::size_t [NUM_PORTS-1:0] wr_size_i,
    output mem_pkg::data_t [NUM_PORTS-1:0] lane_data_o,
    output mem_pkg::strb_t [NUM_PORTS-1:0] lane_strb_o
);
    import mem_pkg::*;

    strb_t size_mask [NUM_PORTS];

    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            case (wr_size_i[p])
                3'd0:    size_mask[p] = strb_t'(8'h01);
                3'd1:    size_mask[p] = strb_t'(8'h03);
                3'd2:    size_mask[p] = strb_t'(8'h0f);
                default: size_mask[p] = strb_t'(8'hff);
            endcase
            // byte offset selects the lanes
            lane_data_o[p] = wdata_i[p] << {addr_i[p][2:0], 3'b000};
            lane_strb_o[p] = size_mask[p] << addr_i[p][2:0];
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_master_bridge.sv
`timescale 1ns/100ps
`default_nettype none

module axi_master_bridge (
    input  logic           clock,
    input  logic           reset,
    input  logic           wr_valid_i,
    input  logic           rd_valid_i,
    input  mem_pkg::addr_t addr_i,
    input  mem_pkg::data_t lane_data_i,
    input  mem_pkg::strb_t lane_strb_i,
    output logic           wr_ok_o,
    output logic           rd_ready_o,
    output mem_pkg::data_t rd_data_o,
    output logic           aw_valid_o,
    input  logic           aw_ready_i,
    output mem_pkg::addr_t aw_addr_o,
    output logic           w_valid_o,
    input  logic           w_ready_i,
    output mem_pkg::data_t w_data_o,
    output mem_pkg::strb_t w_strb_o,
    input  logic           b_valid_i,
    output logic           b_ready_o,
    output logic           ar_valid_o,
    input  logic           ar_ready_i,
    output mem_pkg::addr_t ar_addr_o,
    input  logic           r_valid_i,
    output logic           r_ready_o,
    input  mem_pkg::data_t r_data_i
);
    import mem_pkg::*;

    wr_state_e wr_state_q;
    wr_state_e wr_state_d;
    rd_state_e rd_state_q;
    rd_state_e rd_state_d;
    addr_t     wr_addr_q;
    addr_t     rd_addr_q;
    data_t     wr_data_q;
    data_t     rd_data_q;
    strb_t     wr_strb_q;
    logic      wr_done_q;   // B seen for the write in flight
    logic      wr_changed;
    logic      rd_changed;

    assign wr_changed = (addr_i != wr_addr_q) || (lane_data_i != wr_data_q)
                        || (lane_strb_i != wr_strb_q);
    assign rd_changed = addr_i != rd_addr_q;

    always_comb begin
        wr_state_d = wr_state_q;
        case (wr_state_q)
            wr_idle:
                if (wr_valid_i)
                    wr_state_d = wr_aw_wait;
            wr_aw_wait:
                if (aw_ready_i)
                    wr_state_d = wr_w_wait;
            wr_w_wait:
                if (w_ready_i)
                    wr_state_d = wr_b_done;
            wr_b_done: begin
                // never leave with a B still owed
                if (wr_done_q && !wr_valid_i)
                    wr_state_d = wr_idle;
                else if (wr_done_q && wr_changed)
                    wr_state_d = wr_aw_wait;
            end
            default: wr_state_d = wr_idle;
        endcase
    end

    always_comb begin
        rd_state_d = rd_state_q;
        case (rd_state_q)
            rd_idle:
                if (rd_valid_i)
                    rd_state_d = rd_ar_wait;
            rd_ar_wait:
                if (ar_ready_i)
                    rd_state_d = rd_r_wait;
            rd_r_wait:
                if (r_valid_i)
                    rd_state_d = rd_done;
            rd_done: begin
                if (!rd_valid_i)
                    rd_state_d = rd_idle;
                else if (rd_changed)
                    rd_state_d = rd_ar_wait;
            end
            default: rd_state_d = rd_idle;
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_state_q <= wr_idle;
            rd_state_q <= rd_idle;
            wr_done_q  <= 1'b0;
        end else begin
            wr_state_q <= wr_state_d;
            rd_state_q <= rd_state_d;
            if (wr_state_d != wr_b_done)
                wr_done_q <= 1'b0;
            else if (wr_state_q == wr_b_done && b_valid_i)
                wr_done_q <= 1'b1;
        end
    end

    // request snapshot taken on entry to the address phase
    always_ff @(posedge clock) begin
        if (wr_state_d == wr_aw_wait && wr_state_q != wr_aw_wait) begin
            wr_addr_q <= addr_i;
            wr_data_q <= lane_data_i;
            wr_strb_q <= lane_strb_i;
        end
        if (rd_state_d == rd_ar_wait && rd_state_q != rd_ar_wait)
            rd_addr_q <= addr_i;
        if (rd_state_q == rd_r_wait && r_valid_i)
            rd_data_q <= r_data_i;
    end

    assign aw_valid_o = wr_state_q == wr_aw_wait;
    assign aw_addr_o  = {wr_addr_q[ADDR_W-1:3], 3'b000};  // doubleword aligned
    assign w_valid_o  = wr_state_q == wr_w_wait;
    assign w_data_o   = wr_data_q;
    assign w_strb_o   = wr_strb_q;
    assign b_ready_o  = (wr_state_q == wr_b_done) && b_valid_i;
    assign wr_ok_o    = (wr_state_q == wr_b_done) && wr_done_q && !wr_changed;

    assign ar_valid_o = rd_state_q == rd_ar_wait;
    assign ar_addr_o  = {rd_addr_q[ADDR_W-1:3], 3'b000};
    assign r_ready_o  = rd_state_q == rd_r_wait;
    assign rd_ready_o = (rd_state_q == rd_done) && !rd_changed;
    assign rd_data_o  = rd_ready_o ? rd_data_q : '0;

endmodule

`default_nettype wire

// File: logic/axi_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module axi_arbiter #(
    parameter int NUM_PORTS = 2
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic           [NUM_PORTS-1:0] aw_valid_i,
    output logic           [NUM_PORTS-1:0] aw_ready_o,
    input  mem_pkg::addr_t [NUM_PORTS-1:0] aw_addr_i,
    input  logic           [NUM_PORTS-1:0] w_valid_i,
    output logic           [NUM_PORTS-1:0] w_ready_o,
    input  mem_pkg::data_t [NUM_PORTS-1:0] w_data_i,
    input  mem_pkg::strb_t [NUM_PORTS-1:0] w_strb_i,
    output logic           [NUM_PORTS-1:0] b_valid_o,
    input  logic           [NUM_PORTS-1:0] b_ready_i,
    input  logic           [NUM_PORTS-1:0] ar_valid_i,
    output logic           [NUM_PORTS-1:0] ar_ready_o,
    input  mem_pkg::addr_t [NUM_PORTS-1:0] ar_addr_i,
    output logic           [NUM_PORTS-1:0] r_valid_o,
    input  logic           [NUM_PORTS-1:0] r_ready_i,
    output mem_pkg::data_t [NUM_PORTS-1:0] r_data_o,
    output logic                           m_aw_valid_o,
    input  logic                           m_aw_ready_i,
    output mem_pkg::addr_t                 m_aw_addr_o,
    output logic                           m_w_valid_o,
    input  logic                           m_w_ready_i,
    output mem_pkg::data_t                 m_w_data_o,
    output mem_pkg::strb_t                 m_w_strb_o,
    input  logic                           m_b_valid_i,
    output logic                           m_b_ready_o,
    output logic                           m_ar_valid_o,
    input  logic                           m_ar_ready_i,
    output mem_pkg::addr_t                 m_ar_addr_o,
    input  logic                           m_r_valid_i,
    output logic                           m_r_ready_o,
    input  mem_pkg::data_t                 m_r_data_i
);
    localparam int IDX_W = (NUM_PORTS > 1) ? $clog2(NUM_PORTS) : 1;

    logic [IDX_W-1:0] wr_ptr_q;
    logic [IDX_W-1:0] wr_grant_q;
    logic [IDX_W-1:0] wr_sel;
    logic             wr_busy_q;   // held from AW until B
    logic             wr_found;
    logic [IDX_W-1:0] rd_ptr_q;
    logic [IDX_W-1:0] rd_grant_q;
    logic [IDX_W-1:0] rd_sel;
    logic             rd_busy_q;   // held from AR until R
    logic             rd_found;

    // first requester at or after ptr, returned as {found, index}
    function automatic logic [IDX_W:0] rr_pick(input logic [NUM_PORTS-1:0] req,
                                               input logic [IDX_W-1:0] ptr);
        logic [IDX_W:0] res;
        int             idx;
        res = '0;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % NUM_PORTS;
            if (req[idx])
                res = {1'b1, IDX_W'(idx)};  // nearest offset written last
        end
        return res;
    endfunction

    function automatic logic [IDX_W-1:0] next_idx(input logic [IDX_W-1:0] idx);
        return (int'(idx) == NUM_PORTS - 1) ? '0 : idx + 1'b1;
    endfunction

    always_comb begin
        {wr_found, wr_sel} = rr_pick(aw_valid_i, wr_ptr_q);
        if (wr_busy_q)
            wr_sel = wr_grant_q;
        {rd_found, rd_sel} = rr_pick(ar_valid_i, rd_ptr_q);
        if (rd_busy_q)
            rd_sel = rd_grant_q;
    end

    assign m_aw_valid_o = !wr_busy_q && wr_found;
    assign m_aw_addr_o  = aw_addr_i[wr_sel];
    assign m_w_valid_o  = wr_busy_q && w_valid_i[wr_sel];
    assign m_w_data_o   = w_data_i[wr_sel];
    assign m_w_strb_o   = w_strb_i[wr_sel];
    assign m_b_ready_o  = wr_busy_q && b_ready_i[wr_sel];

    assign m_ar_valid_o = !rd_busy_q && rd_found;
    assign m_ar_addr_o  = ar_addr_i[rd_sel];
    assign m_r_ready_o  = rd_busy_q && r_ready_i[rd_sel];

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            aw_ready_o[i] = m_aw_valid_o && (int'(wr_sel) == i) && m_aw_ready_i;
            w_ready_o[i]  = wr_busy_q && (int'(wr_sel) == i) && m_w_ready_i;
            b_valid_o[i]  = wr_busy_q && (int'(wr_sel) == i) && m_b_valid_i;
            ar_ready_o[i] = m_ar_valid_o && (int'(rd_sel) == i) && m_ar_ready_i;
            r_valid_o[i]  = rd_busy_q && (int'(rd_sel) == i) && m_r_valid_i;
            r_data_o[i]   = m_r_data_i;  // qualified by r_valid
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr_q   <= '0;
            wr_grant_q <= '0;
            wr_busy_q  <= 1'b0;
            rd_ptr_q   <= '0;
            rd_grant_q <= '0;
            rd_busy_q  <= 1'b0;
        end else begin
            if (m_aw_valid_o && m_aw_ready_i) begin
                wr_busy_q  <= 1'b1;
                wr_grant_q <= wr_sel;
            end else if (m_b_valid_i && m_b_ready_o) begin
                wr_busy_q <= 1'b0;
                wr_ptr_q  <= next_idx(wr_grant_q);
            end
            if (m_ar_valid_o && m_ar_ready_i) begin
                rd_busy_q  <= 1'b1;
                rd_grant_q <= rd_sel;
            end else if (m_r_valid_i && m_r_ready_o) begin
                rd_busy_q <= 1'b0;
                rd_ptr_q  <= next_idx(rd_grant_q);
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/axi_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_sram #(
    parameter int MEM_WORDS = 256
) (
    input  logic           clock,
    input  logic           reset,
    input  logic           aw_valid_i,
    output logic           aw_ready_o,
    input  mem_pkg::addr_t aw_addr_i,
    input  logic           w_valid_i,
    output logic           w_ready_o,
    input  mem_pkg::data_t w_data_i,
    input  mem_pkg::strb_t w_strb_i,
    output logic           b_valid_o,
    input  logic           b_ready_i,
    input  logic           ar_valid_i,
    output logic           ar_ready_o,
    input  mem_pkg::addr_t ar_addr_i,
    output logic           r_valid_o,
    input  logic           r_ready_i,
    output mem_pkg::data_t r_data_o
);
    import mem_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    typedef enum logic [1:0] {s_wr_addr, s_wr_data, s_wr_resp} wr_phase_e;
    typedef enum logic {s_rd_addr, s_rd_data} rd_phase_e;

    data_t            mem [MEM_WORDS];
    wr_phase_e        wr_q;
    rd_phase_e        rd_q;
    logic [IDX_W-1:0] wr_idx_q;
    data_t            rd_data_q;

    function automatic logic [IDX_W-1:0] word_idx(input addr_t addr);
        return IDX_W'((addr >> 3) % MEM_WORDS);  // wraps past the top
    endfunction

    assign aw_ready_o = wr_q == s_wr_addr;
    assign w_ready_o  = wr_q == s_wr_data;
    assign b_valid_o  = wr_q == s_wr_resp;
    assign ar_ready_o = rd_q == s_rd_addr;
    assign r_valid_o  = rd_q == s_rd_data;
    assign r_data_o   = rd_data_q;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_q <= s_wr_addr;
            rd_q <= s_rd_addr;
        end else begin
            case (wr_q)
                s_wr_addr: if (aw_valid_i) wr_q <= s_wr_data;
                s_wr_data: if (w_valid_i) wr_q <= s_wr_resp;
                default:   if (b_ready_i) wr_q <= s_wr_addr;
            endcase
            if (ar_ready_o && ar_valid_i)
                rd_q <= s_rd_data;
            else if (r_valid_o && r_ready_i)
                rd_q <= s_rd_addr;
        end
    end

    always_ff @(posedge clock) begin
        if (aw_ready_o && aw_valid_i)
            wr_idx_q <= word_idx(aw_addr_i);
        if (w_ready_o && w_valid_i) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (w_strb_i[b])
                    mem[wr_idx_q][8*b +: 8] <= w_data_i[8*b +: 8];
            end
        end
        // same-edge write is not visible here, old data returned
        if (ar_ready_o && ar_valid_i)
            rd_data_q <= mem[word_idx(ar_addr_i)];
    end

endmodule

`default_nettype wire

// File: logic/mem_subsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_top #(
    parameter int NUM_PORTS = 2,
    parameter int MEM_WORDS = 256
) (
    input  logic                           clock,
    input  logic                           reset,
    input  logic           [NUM_PORTS-1:0] wr_valid_i,
    input  logic           [NUM_PORTS-1:0] rd_valid_i,
    input  mem_pkg::addr_t [NUM_PORTS-1:0] addr_i,
    input  mem_pkg::data_t [NUM_PORTS-1:0] wdata_i,
    input  mem_pkg::size_t [NUM_PORTS-1:0] wr_size_i,
    output logic           [NUM_PORTS-1:0] wr_ok_o,
    output logic           [NUM_PORTS-1:0] rd_ready_o,
    output mem_pkg::data_t [NUM_PORTS-1:0] rd_data_o
);
    import mem_pkg::*;

    data_t [NUM_PORTS-1:0] lane_data;
    strb_t [NUM_PORTS-1:0] lane_strb;

    // bridge side, one slice per port
    logic  [NUM_PORTS-1:0] aw_valid;
    logic  [NUM_PORTS-1:0] aw_ready;
    addr_t [NUM_PORTS-1:0] aw_addr;
    logic  [NUM_PORTS-1:0] w_valid;
    logic  [NUM_PORTS-1:0] w_ready;
    data_t [NUM_PORTS-1:0] w_data;
    strb_t [NUM_PORTS-1:0] w_strb;
    logic  [NUM_PORTS-1:0] b_valid;
    logic  [NUM_PORTS-1:0] b_ready;
    logic  [NUM_PORTS-1:0] ar_valid;
    logic  [NUM_PORTS-1:0] ar_ready;
    addr_t [NUM_PORTS-1:0] ar_addr;
    logic  [NUM_PORTS-1:0] r_valid;
    logic  [NUM_PORTS-1:0] r_ready;
    data_t [NUM_PORTS-1:0] r_data;

    // memory side
    logic  m_aw_valid;
    logic  m_aw_ready;
    addr_t m_aw_addr;
    logic  m_w_valid;
    logic  m_w_ready;
    data_t m_w_data;
    strb_t m_w_strb;
    logic  m_b_valid;
    logic  m_b_ready;
    logic  m_ar_valid;
    logic  m_ar_ready;
    addr_t m_ar_addr;
    logic  m_r_valid;
    logic  m_r_ready;
    data_t m_r_data;

    req_format #(
        .NUM_PORTS (NUM_PORTS)
    ) req_format_inst (
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .wr_size_i   (wr_size_i),
        .lane_data_o (lane_data),
        .lane_strb_o (lane_strb)
    );

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_bridge
        axi_master_bridge axi_master_bridge_inst (
            .clock       (clock),
            .reset       (reset),
            .wr_valid_i  (wr_valid_i[p]),
            .rd_valid_i  (rd_valid_i[p]),
            .addr_i      (addr_i[p]),
            .lane_data_i (lane_data[p]),
            .lane_strb_i (lane_strb[p]),
            .wr_ok_o     (wr_ok_o[p]),
            .rd_ready_o  (rd_ready_o[p]),
            .rd_data_o   (rd_data_o[p]),
            .aw_valid_o  (aw_valid[p]),
            .aw_ready_i  (aw_ready[p]),
            .aw_addr_o   (aw_addr[p]),
            .w_valid_o   (w_valid[p]),
            .w_ready_i   (w_ready[p]),
            .w_data_o    (w_data[p]),
            .w_strb_o    (w_strb[p]),
            .b_valid_i   (b_valid[p]),
            .b_ready_o   (b_ready[p]),
            .ar_valid_o  (ar_valid[p]),
            .ar_ready_i  (ar_ready[p]),
            .ar_addr_o   (ar_addr[p]),
            .r_valid_i   (r_valid[p]),
            .r_ready_o   (r_ready[p]),
            .r_data_i    (r_data[p])
        );
    end

    axi_arbiter #(
        .NUM_PORTS (NUM_PORTS)
    ) axi_arbiter_inst (
        .clock        (clock),
        .reset        (reset),
        .aw_valid_i   (aw_valid),
        .aw_ready_o   (aw_ready),
        .aw_addr_i    (aw_addr),
        .w_valid_i    (w_valid),
        .w_ready_o    (w_ready),
        .w_data_i     (w_data),
        .w_strb_i     (w_strb),
        .b_valid_o    (b_valid),
        .b_ready_i    (b_ready),
        .ar_valid_i   (ar_valid),
        .ar_ready_o   (ar_ready),
        .ar_addr_i    (ar_addr),
        .r_valid_o    (r_valid),
        .r_ready_i    (r_ready),
        .r_data_o     (r_data),
        .m_aw_valid_o (m_aw_valid),
        .m_aw_ready_i (m_aw_ready),
        .m_aw_addr_o  (m_aw_addr),
        .m_w_valid_o  (m_w_valid),
        .m_w_ready_i  (m_w_ready),
        .m_w_data_o   (m_w_data),
        .m_w_strb_o   (m_w_strb),
        .m_b_valid_i  (m_b_valid),
        .m_b_ready_o  (m_b_ready),
        .m_ar_valid_o (m_ar_valid),
        .m_ar_ready_i (m_ar_ready),
        .m_ar_addr_o  (m_ar_addr),
        .m_r_valid_i  (m_r_valid),
        .m_r_ready_o  (m_r_ready),
        .m_r_data_i   (m_r_data)
    );

    axi_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) axi_sram_inst (
        .clock      (clock),
        .reset      (reset),
        .aw_valid_i (m_aw_valid),
        .aw_ready_o (m_aw_ready),
        .aw_addr_i  (m_aw_addr),
        .w_valid_i  (m_w_valid),
        .w_ready_o  (m_w_ready),
        .w_data_i   (m_w_data),
        .w_strb_i   (m_w_strb),
        .b_valid_o  (m_b_valid),
        .b_ready_i  (m_b_ready),
        .ar_valid_i (m_ar_valid),
        .ar_ready_o (m_ar_ready),
        .ar_addr_i  (m_ar_addr),
        .r_valid_o  (m_r_valid),
        .r_ready_i  (m_r_ready),
        .r_data_o   (m_r_data)
    );

endmodule

`default_nettype wire

// File: verif/tb_mem_subsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;
    import mem_pkg::*;

    localparam int NUM_PORTS      = 2;
    localparam int MEM_WORDS      = 256;
    localparam int MEM_BYTES      = MEM_WORDS * 8;
    localparam int CLK_PERIOD     = 40;
    localparam int TIMEOUT_CYCLES = 100;
    localparam int SEED           = 47557;

    logic                  clock;
    logic                  reset;
    logic [NUM_PORTS-1:0]  wr_valid;
    logic [NUM_PORTS-1:0]  rd_valid;
    addr_t [NUM_PORTS-1:0] addr_in;
    data_t [NUM_PORTS-1:0] wdata_in;
    size_t [NUM_PORTS-1:0] wr_size_in;
    logic [NUM_PORTS-1:0]  wr_ok;
    logic [NUM_PORTS-1:0]  rd_ready;
    data_t [NUM_PORTS-1:0] rd_data;

    logic [7:0] model_mem [MEM_BYTES];  // byte image of the sram
    data_t      conc_data [NUM_PORTS][4];
    int         check_count;
    int         error_count;
    int         test_count;
    int         test_errors_start;

    mem_subsys_top #(
        .NUM_PORTS (NUM_PORTS),
        .MEM_WORDS (MEM_WORDS)
    ) mem_subsys_top_inst (
        .clock      (clock),
        .reset      (reset),
        .wr_valid_i (wr_valid),
        .rd_valid_i (rd_valid),
        .addr_i     (addr_in),
        .wdata_i    (wdata_in),
        .wr_size_i  (wr_size_in),
        .wr_ok_o    (wr_ok),
        .rd_ready_o (rd_ready),
        .rd_data_o  (rd_data)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected 0x%h, got 0x%h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    // low 2**s bytes of d land at a
    function automatic void model_write(input addr_t a, input data_t d, input size_t s);
        int base;
        base = int'(a % addr_t'(MEM_BYTES));
        for (int i = 0; i < (1 << s); i++)
            model_mem[base + i] = d[8*i +: 8];
    endfunction

    function automatic data_t model_word(input addr_t a);
        data_t w;
        int    base;
        base = int'(a % addr_t'(MEM_BYTES));
        base = base - base % 8;
        for (int i = 0; i < 8; i++)
            w[8*i +: 8] = model_mem[base + i];
        return w;
    endfunction

    function automatic addr_t word_addr(input int word, input int off);
        return addr_t'(word * 8 + off);
    endfunction

    function automatic int rand_offset(input size_t s);
        return int'(($urandom % (8 >> s)) << s);  // aligned to size
    endfunction

    function automatic data_t fill_pattern(input addr_t a);
        return {a ^ 32'h5a3c_96e1, ~a};
    endfunction

    task automatic start_write(input int port, input addr_t a, input data_t d, input size_t s);
        @(posedge clock);
        wr_valid[port]   <= 1'b1;
        addr_in[port]    <= a;
        wdata_in[port]   <= d;
        wr_size_in[port] <= s;
    endtask

    task automatic start_read(input int port, input addr_t a);
        @(posedge clock);
        rd_valid[port] <= 1'b1;
        addr_in[port]  <= a;
    endtask

    task automatic wait_done(input int port, input bit is_write, output bit done);
        int cycles;
        cycles = 0;
        done   = 1'b0;
        while (!done && cycles < TIMEOUT_CYCLES) begin
            @(negedge clock);
            cycles++;
            done = is_write ? wr_ok[port] : rd_ready[port];
        end
        if (!done) begin
            error_count++;
            $display("port %0d: %s did not complete within %0d cycles",
                     port, is_write ? "write" : "read", TIMEOUT_CYCLES);
        end
    endtask

    task automatic release_port(input int port);
        @(posedge clock);
        wr_valid[port] <= 1'b0;
        rd_valid[port] <= 1'b0;
    endtask

    task automatic write_op(input int port, input addr_t a, input data_t d, input size_t s);
        bit done;
        start_write(port, a, d, s);
        wait_done(port, 1'b1, done);
        if (done)
            model_write(a, d, s);
        release_port(port);
    endtask

    task automatic read_check(input int port, input addr_t a);
        bit done;
        start_read(port, a);
        wait_done(port, 1'b0, done);
        if (done)
            check_value($sformatf("rd_data_o[%0d]", port), model_word(a), rd_data[port]);
        release_port(port);
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %-16s %s, %0d errors", test_count, name,
                 (error_count == test_errors_start) ? "ok" : "failed",
                 error_count - test_errors_start);
        test_errors_start = error_count;
    endtask

    // no completion and no read data on any port
    task automatic check_idle_outputs();
        check_value("wr_ok_o", 64'd0, 64'(wr_ok));
        check_value("rd_ready_o", 64'd0, 64'(rd_ready));
        for (int p = 0; p < NUM_PORTS; p++)
            check_value($sformatf("rd_data_o[%0d]", p), 64'd0, rd_data[p]);
    endtask

    task automatic reset_phase();
        repeat (3) begin
            @(negedge clock);
            check_idle_outputs();
        end
        @(posedge clock);
        reset <= 1'b1;
        repeat (2) begin
            @(negedge clock);
            check_idle_outputs();
        end
        report_test("reset");
    endtask

    task automatic full_word_rw();
        addr_t a;
        for (int p = 0; p < NUM_PORTS; p++) begin
            a = word_addr(p, 0);
            write_op(p, a, {$urandom, $urandom}, 3'd3);
            read_check(p, a);
        end
        report_test("full word");
    endtask

    task automatic sized_merge();
        addr_t a;
        size_t s;
        for (int w = 2; w < 6; w++)
            write_op(w % 2, word_addr(w, 0), {$urandom, $urandom}, 3'd3);
        for (int n = 0; n < 12; n++) begin
            s = size_t'($urandom % 3);
            a = word_addr(2 + n % 4, rand_offset(s));
            write_op(n % 2, a, {$urandom, $urandom}, s);
            read_check((n + 1) % 2, a);  // other port sees the merge
        end
        report_test("sized writes");
    endtask

    task automatic port_sequence(input int port, input int base);
        addr_t a;
        size_t s;
        for (int i = 0; i < 4; i++) begin
            s = size_t'(i % 3);
            a = word_addr(base + i, 0);
            write_op(port, a, conc_data[port][i], 3'd3);
            read_check(port, a);
            a = word_addr(base + i, 8 - (1 << s));
            write_op(port, a, ~conc_data[port][i], s);
            read_check(port, a);
        end
    endtask

    task automatic concurrent_ports();
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int i = 0; i < 4; i++)
                conc_data[p][i] = {$urandom, $urandom};
        end
        fork
            port_sequence(0, 32);
            port_sequence(1, 40);
        join
        report_test("concurrency");
    endtask

    task automatic held_completion();
        bit    done;
        addr_t a1;
        addr_t a2;
        data_t d;
        a1 = word_addr(48, 0);
        a2 = word_addr(49, 0);
        d  = {$urandom, $urandom};
        write_op(1, a2, fill_pattern(a2), 3'd3);
        start_write(0, a1, d, 3'd3);
        wait_done(0, 1'b1, done);
        if (done)
            model_write(a1, d, 3'd3);
        repeat (5) begin
            @(negedge clock);
            check_value("wr_ok_o[0]", 64'd1, 64'(wr_ok[0]));
        end
        @(posedge clock);
        addr_in[0] <= a2;   // same data to a new target
        @(negedge clock);
        check_value("wr_ok_o[0]", 64'd0, 64'(wr_ok[0]));
        wait_done(0, 1'b1, done);
        if (done)
            model_write(a2, d, 3'd3);
        release_port(0);
        start_read(1, a1);
        wait_done(1, 1'b0, done);
        repeat (5) begin
            @(negedge clock);
            check_value("rd_ready_o[1]", 64'd1, 64'(rd_ready[1]));
            check_value("rd_data_o[1]", model_word(a1), rd_data[1]);
        end
        @(posedge clock);
        addr_in[1] <= a2;
        @(negedge clock);
        check_value("rd_ready_o[1]", 64'd0, 64'(rd_ready[1]));
        wait_done(1, 1'b0, done);
        if (done)
            check_value("rd_data_o[1]", model_word(a2), rd_data[1]);
        release_port(1);
        report_test("held completion");
    endtask

    task automatic random_mix();
        int    port;
        addr_t a;
        size_t s;
        // every word in the window gets defined contents first
        for (int w = 0; w < 32; w++)
            write_op(w % 2, word_addr(w, 0), fill_pattern(word_addr(w, 0)), 3'd3);
        for (int n = 0; n < 200; n++) begin
            port = int'($urandom % 2);
            s    = size_t'($urandom % 4);
            a    = word_addr(int'($urandom % 32), rand_offset(s));
            if ($urandom % 2 == 0)
                write_op(port, a, {$urandom, $urandom}, s);
            else
                read_check(port, a);
        end
        report_test("random mix");
    endtask

    initial begin
        reset             = 1'b0;
        wr_valid          = '0;
        rd_valid          = '0;
        addr_in           = '0;
        wdata_in          = '0;
        wr_size_in        = '0;
        check_count       = 0;
        error_count       = 0;
        test_count        = 0;
        test_errors_start = 0;
        void'($urandom(SEED));

        reset_phase();
        full_word_rw();
        sized_merge();
        concurrent_ports();
        held_completion();
        random_mix();

        $display("tests: %0d  checks: %0d  errors: %0d", test_count, check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/mem_pkg.sv
logic/req_format.sv
logic/axi_master_bridge.sv
logic/axi_arbiter.sv
logic/axi_sram.sv
logic/mem_subsys_top.sv
verif/tb_mem_subsys.sv

// File: run_sim.sh
#!/bin/sh
# build and run the memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -f build.f \
    --top-module tb_mem_subsys -Mdir obj_dir -o tb_mem_subsys

output=$(./obj_dir/tb_mem_subsys)
echo "$output"

if echo "$output" | grep -qF "*** TEST PASSED ***"; then
    exit 0
fi
exit 1
